// File: verilog/zipdbg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Debug port definitions for the soft-core wrapper
// Bus widths, control word bit map, reset hold length
// and the vector types shared by the debug slave and control block
//////////////////////////////////////////////////////////////////////
`default_nettype none

package zipdbg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus geometry
	//////////////////////////////////////////////////////////////////////
	localparam int DBG_ADDR_WIDTH = 8;
	localparam int DBG_DATA_WIDTH = 32;
	// Byte offset bits below the word address
	localparam int DBG_WORD_LSB = 2;
	// Word address bit, 0 for control and 1 for CPU registers
	localparam int DBG_SEL_BIT = 5;

	//////////////////////////////////////////////////////////////////////
	// Control word bits
	//////////////////////////////////////////////////////////////////////
	localparam int HALT_BIT = 0;
	localparam int STEP_BIT = 2;
	localparam int RESET_BIT = 3;
	localparam int CLEAR_CACHE_BIT = 4;
	localparam int CATCH_BIT = 5;

	// Core held in reset this many cycles
	localparam int RESET_DURATION = 10;
	// Core comes up halted, catch comes up set
	localparam logic START_HALTED = 1'b1;

	//////////////////////////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////////////////////////
	typedef logic [DBG_DATA_WIDTH-1:0] dbg_word_t;
	typedef logic [DBG_DATA_WIDTH/8-1:0] dbg_strb_t;
	typedef logic [DBG_ADDR_WIDTH-1:0] dbg_addr_t;
	typedef logic [DBG_ADDR_WIDTH-DBG_WORD_LSB-1:0] dbg_waddr_t;
	typedef logic [4:0] cpu_reg_t;
	// Bit 0 sleep, bit 1 user mode
	typedef logic [2:0] dbg_cc_t;
	// Always OKAY on this port
	typedef logic [1:0] bus_resp_t;

endpackage

`default_nettype wire

// File: verilog/dbg_skidbuffer.sv
//////////////////////////////////////////////////////////////////////
// One-deep skid buffer for an AXI-lite request channel
// Keeps one beat when the output stalls, so input ready is a register
//////////////////////////////////////////////////////////////////////
`default_nettype none

module dbg_skidbuffer #(
	parameter int DW = 8
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Upstream side
	input wire i_valid,
	output logic o_ready,
	input wire [DW-1:0] i_data,
	// Downstream side
	output logic o_valid,
	input wire i_ready,
	output logic [DW-1:0] o_data
);

	// Overflow beat
	logic r_valid;
	logic [DW-1:0] r_data;

	// Capture when the beat arrives but downstream is stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	// Ready high out of reset, low while a beat is held
	assign o_ready = !r_valid;

	assign o_valid = i_valid || r_valid;
	// Held beat goes first
	assign o_data = r_valid ? r_data : i_data;

endmodule

`default_nettype wire

// File: verilog/dbg_axil_slave.sv
//////////////////////////////////////////////////////////////////////
// AXI-lite debug slave
// Orders AW, W, B, AR and R beats, splits control from CPU targets,
// registers the CPU register write and read paths
//////////////////////////////////////////////////////////////////////
`default_nettype none

module dbg_axil_slave (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Write address
	input wire i_awvalid,
	output logic o_awready,
	input wire zipdbg_pkg::dbg_addr_t i_awaddr,
	// Write data
	input wire i_wvalid,
	output logic o_wready,
	input wire zipdbg_pkg::dbg_word_t i_wdata,
	input wire zipdbg_pkg::dbg_strb_t i_wstrb,
	// Write response
	output logic o_bvalid,
	input wire i_bready,
	output zipdbg_pkg::bus_resp_t o_bresp,
	// Read address
	input wire i_arvalid,
	output logic o_arready,
	input wire zipdbg_pkg::dbg_addr_t i_araddr,
	// Read data
	output logic o_rvalid,
	input wire i_rready,
	output zipdbg_pkg::dbg_word_t o_rdata,
	output zipdbg_pkg::bus_resp_t o_rresp,
	// CPU debug port
	output logic o_dbg_we,
	output zipdbg_pkg::cpu_reg_t o_dbg_wreg,
	output zipdbg_pkg::dbg_word_t o_dbg_data,
	output zipdbg_pkg::cpu_reg_t o_dbg_rreg,
	input wire zipdbg_pkg::dbg_word_t i_dbg_reg,
	input wire i_dbg_stall,
	// Control block side
	input wire zipdbg_pkg::dbg_word_t i_status,
	output logic o_cmd_write,
	output zipdbg_pkg::dbg_word_t o_cmd_data,
	output zipdbg_pkg::dbg_strb_t o_cmd_strb,
	output logic o_cpu_write,
	output logic o_write_pending
);

	localparam int SEL = zipdbg_pkg::DBG_SEL_BIT;
	localparam int AW = zipdbg_pkg::DBG_ADDR_WIDTH;
	localparam int LSB = zipdbg_pkg::DBG_WORD_LSB;
	localparam int WDW = $bits(zipdbg_pkg::dbg_word_t) + $bits(zipdbg_pkg::dbg_strb_t);

	logic awskd_valid, wskd_valid, arskd_valid;
	zipdbg_pkg::dbg_waddr_t awskd_addr, arskd_addr;
	zipdbg_pkg::dbg_word_t wskd_data;
	zipdbg_pkg::dbg_strb_t wskd_strb;
	logic write_ready, read_ready, write_stall;
	logic w_cpu_write, dbg_write_valid, dbg_read_valid;

	//////////////////////////////////////////////////////////////////////
	// Write path
	//////////////////////////////////////////////////////////////////////
	dbg_skidbuffer #(.DW($bits(zipdbg_pkg::dbg_waddr_t))) u_awskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_awvalid), .o_ready(o_awready), .i_data(i_awaddr[AW-1:LSB]),
		.o_valid(awskd_valid), .i_ready(write_ready), .o_data(awskd_addr)
	);

	dbg_skidbuffer #(.DW(WDW)) u_wskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_wvalid), .o_ready(o_wready), .i_data({ i_wstrb, i_wdata }),
		.o_valid(wskd_valid), .i_ready(write_ready), .o_data({ wskd_strb, wskd_data })
	);

	// Core write still waiting on a stalled core
	assign write_stall = dbg_write_valid && i_dbg_stall;

	// Both halves present, B free, and no CPU write blocked by a stall
	assign write_ready = awskd_valid && wskd_valid
		&& (!awskd_addr[SEL] || (wskd_strb == '0) || !write_stall)
		&& (!o_bvalid || i_bready);

	assign w_cpu_write = write_ready && awskd_addr[SEL] && (|wskd_strb);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			dbg_write_valid <= 1'b0;
		else if (!write_stall)
			dbg_write_valid <= w_cpu_write;
	end

	// Register number and data hold with the strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!write_stall)
		begin
			o_dbg_wreg <= awskd_addr[SEL-1:0];
			o_dbg_data <= wskd_data;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	assign o_bresp = '0;
	assign o_dbg_we = dbg_write_valid;
	assign o_write_pending = dbg_write_valid;

	// Control word commands, one cycle strobes
	assign o_cmd_write = write_ready && !awskd_addr[SEL];
	assign o_cmd_data = wskd_data;
	assign o_cmd_strb = wskd_strb;
	assign o_cpu_write = w_cpu_write;

	//////////////////////////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////////////////////////
	dbg_skidbuffer #(.DW($bits(zipdbg_pkg::dbg_waddr_t))) u_arskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_arvalid), .o_ready(o_arready), .i_data(i_araddr[AW-1:LSB]),
		.o_valid(arskd_valid), .i_ready(read_ready), .o_data(arskd_addr)
	);

	// One read at a time, R free or being taken
	assign read_ready = arskd_valid && !dbg_read_valid && (!o_rvalid || i_rready);
	assign o_dbg_rreg = arskd_addr[SEL-1:0];

	// CPU read in flight, core answers next cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			dbg_read_valid <= 1'b0;
		else
			dbg_read_valid <= read_ready && arskd_addr[SEL];
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_ready && !arskd_addr[SEL]) || dbg_read_valid;
	end

	// Status unless a CPU register answer is due
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
			o_rdata <= dbg_read_valid ? i_dbg_reg : i_status;
	end

	assign o_rresp = '0;

endmodule

`default_nettype wire

// File: verilog/dbg_control.sv
//////////////////////////////////////////////////////////////////////
// Debug control block
// Halt, step, reset, clear-cache and catch registers,
// the power-on reset hold and the status word
//////////////////////////////////////////////////////////////////////
`default_nettype none

module dbg_control (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire i_cpu_reset,
	input wire i_interrupt,
	// From the debug slave
	input wire i_cmd_write,
	input wire zipdbg_pkg::dbg_word_t i_cmd_data,
	input wire zipdbg_pkg::dbg_strb_t i_cmd_strb,
	input wire i_cpu_write,
	input wire i_write_pending,
	// From the core
	input wire i_dbg_stall,
	input wire i_dbg_break,
	input wire zipdbg_pkg::dbg_cc_t i_dbg_cc,
	// Outputs
	output logic o_halt,
	output logic o_cmd_reset,
	output logic o_clear_cache,
	output zipdbg_pkg::dbg_word_t o_status
);

	logic reset_request, release_request, halt_request;
	logic step_request, clear_cache_request;
	logic cmd_step, catch;
	logic [$clog2(zipdbg_pkg::RESET_DURATION+1)-1:0] reset_counter;

	//////////////////////////////////////////////////////////////////////
	// Request decode, each bit qualified by its strobe byte
	//////////////////////////////////////////////////////////////////////
	assign reset_request = i_cmd_write && i_cmd_strb[zipdbg_pkg::RESET_BIT/8]
		&& i_cmd_data[zipdbg_pkg::RESET_BIT];
	assign release_request = i_cmd_write && i_cmd_strb[zipdbg_pkg::HALT_BIT/8]
		&& !i_cmd_data[zipdbg_pkg::HALT_BIT];
	assign halt_request = i_cmd_write && i_cmd_strb[zipdbg_pkg::HALT_BIT/8]
		&& i_cmd_data[zipdbg_pkg::HALT_BIT];
	assign step_request = i_cmd_write && i_cmd_strb[zipdbg_pkg::STEP_BIT/8]
		&& i_cmd_data[zipdbg_pkg::STEP_BIT];
	assign clear_cache_request = i_cmd_write
		&& i_cmd_strb[zipdbg_pkg::CLEAR_CACHE_BIT/8]
		&& i_cmd_data[zipdbg_pkg::CLEAR_CACHE_BIT];

	// Reset hold countdown, restarted by bus or CPU reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_counter <= zipdbg_pkg::RESET_DURATION[$bits(reset_counter)-1:0];
		else if (reset_counter != '0)
			reset_counter <= reset_counter - 1'b1;
	end

	// Held through the countdown, then pulses on request or uncaught break
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_reset <= 1'b1;
		else if (reset_counter > 1)
			o_cmd_reset <= 1'b1;
		else if (i_dbg_break && !catch)
			o_cmd_reset <= 1'b1;
		else
			o_cmd_reset <= reset_request;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_halt <= zipdbg_pkg::START_HALTED;
		else if (o_cmd_reset && zipdbg_pkg::START_HALTED)
			o_halt <= zipdbg_pkg::START_HALTED;
		else
		begin
			// Release only once the core has fully stopped
			if (!i_write_pending && !i_dbg_stall && (release_request || step_request))
				o_halt <= 1'b0;
			// Later assignments win, any halt reason overrides release
			if (i_dbg_break && catch)
				o_halt <= 1'b1;
			if (halt_request && !step_request)
				o_halt <= 1'b1;
			if (i_cpu_write)
				o_halt <= 1'b1;
			// Back to halted after a step
			if (cmd_step)
				o_halt <= 1'b1;
			if (o_clear_cache || clear_cache_request)
				o_halt <= 1'b1;
		end
	end

	// Clear cache lasts until the core is halted and idle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_cmd_reset)
			o_clear_cache <= 1'b0;
		else if (clear_cache_request && halt_request)
			o_clear_cache <= 1'b1;
		else if (o_halt && !i_dbg_stall)
			o_clear_cache <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_step <= 1'b0;
		else if (step_request)
			cmd_step <= 1'b1;
		else if (!i_dbg_stall)
			cmd_step <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			catch <= zipdbg_pkg::START_HALTED;
		else if (i_cmd_write && i_cmd_strb[zipdbg_pkg::CATCH_BIT/8])
			catch <= i_cmd_data[zipdbg_pkg::CATCH_BIT];
	end

	//////////////////////////////////////////////////////////////////////
	// Status word
	//////////////////////////////////////////////////////////////////////
	// 11 break, 10 interrupt, 9:8 user/sleep, 5 catch, 3 reset
	// 1 halted, 0 halt request
	assign o_status = { 20'h0, i_dbg_break, i_interrupt, i_dbg_cc[1:0],
		2'b00, catch, 1'b0, o_cmd_reset, 1'b0, !i_dbg_stall, o_halt };

endmodule

`default_nettype wire

// File: verilog/zipdbg_top.sv
//////////////////////////////////////////////////////////////////////
// Debug wrapper top level
// AXI-lite debug slave feeding the halt/step/reset control block
//////////////////////////////////////////////////////////////////////
`default_nettype none

module zipdbg_top (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// AXI-lite debug bus
	input wire i_awvalid,
	output logic o_awready,
	input wire zipdbg_pkg::dbg_addr_t i_awaddr,
	input wire i_wvalid,
	output logic o_wready,
	input wire zipdbg_pkg::dbg_word_t i_wdata,
	input wire zipdbg_pkg::dbg_strb_t i_wstrb,
	output logic o_bvalid,
	input wire i_bready,
	output zipdbg_pkg::bus_resp_t o_bresp,
	input wire i_arvalid,
	output logic o_arready,
	input wire zipdbg_pkg::dbg_addr_t i_araddr,
	output logic o_rvalid,
	input wire i_rready,
	output zipdbg_pkg::dbg_word_t o_rdata,
	output zipdbg_pkg::bus_resp_t o_rresp,
	// CPU debug port
	output logic o_dbg_we,
	output zipdbg_pkg::cpu_reg_t o_dbg_wreg,
	output zipdbg_pkg::dbg_word_t o_dbg_data,
	output zipdbg_pkg::cpu_reg_t o_dbg_rreg,
	input wire zipdbg_pkg::dbg_word_t i_dbg_reg,
	input wire i_dbg_stall,
	// Core control and status
	input wire i_cpu_reset,
	input wire i_interrupt,
	input wire i_dbg_break,
	input wire zipdbg_pkg::dbg_cc_t i_dbg_cc,
	output logic o_halt,
	output logic o_cmd_reset,
	output logic o_clear_cache
);

	// Slave to control block
	zipdbg_pkg::dbg_word_t status, cmd_data;
	zipdbg_pkg::dbg_strb_t cmd_strb;
	logic cmd_write, cpu_write, write_pending;

	dbg_axil_slave u_slave (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
		.o_dbg_we(o_dbg_we), .o_dbg_wreg(o_dbg_wreg), .o_dbg_data(o_dbg_data),
		.o_dbg_rreg(o_dbg_rreg), .i_dbg_reg(i_dbg_reg), .i_dbg_stall(i_dbg_stall),
		.i_status(status), .o_cmd_write(cmd_write), .o_cmd_data(cmd_data),
		.o_cmd_strb(cmd_strb), .o_cpu_write(cpu_write), .o_write_pending(write_pending)
	);

	dbg_control u_control (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset), .i_interrupt(i_interrupt),
		.i_cmd_write(cmd_write), .i_cmd_data(cmd_data), .i_cmd_strb(cmd_strb),
		.i_cpu_write(cpu_write), .i_write_pending(write_pending),
		.i_dbg_stall(i_dbg_stall), .i_dbg_break(i_dbg_break), .i_dbg_cc(i_dbg_cc),
		.o_halt(o_halt), .o_cmd_reset(o_cmd_reset), .o_clear_cache(o_clear_cache),
		.o_status(status)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock source, 10 ns period
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_clock (
	output logic o_clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

// File: tests/zipdbg_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the debug wrapper
// Table of bus operations, a small core model, compare tasks,
// a watchdog and a closing result line
//////////////////////////////////////////////////////////////////////
`default_nettype none

module zipdbg_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int OP_WRITE = 0;
	localparam int OP_READ = 1;
	localparam int OP_BREAK = 2;
	localparam int OP_CPUWR = 3;
	localparam int OP_CPURD = 4;
	localparam int OP_RDHOLD = 5;
	localparam int NUM_ENTRIES = 27;

	logic clk, aresetn, awvalid, wvalid, bready, arvalid, rready;
	logic cpu_reset, interrupt, dbg_break, dbg_stall;
	zipdbg_pkg::dbg_addr_t awaddr, araddr;
	zipdbg_pkg::dbg_word_t wdata, rdata, core_rdata, dbg_data;
	zipdbg_pkg::dbg_strb_t wstrb;
	zipdbg_pkg::bus_resp_t bresp, rresp;
	zipdbg_pkg::cpu_reg_t dbg_wreg, dbg_rreg;
	zipdbg_pkg::dbg_cc_t dbg_cc;
	logic awready, wready, bvalid, arready, rvalid, dbg_we;
	logic halt, cmd_reset, clear_cache;

	// Stimulus table
	int op [NUM_ENTRIES];
	zipdbg_pkg::dbg_addr_t t_addr [NUM_ENTRIES];
	zipdbg_pkg::dbg_word_t t_data [NUM_ENTRIES];
	zipdbg_pkg::dbg_strb_t t_strb [NUM_ENTRIES];
	zipdbg_pkg::dbg_word_t t_expect [NUM_ENTRIES];
	int n_entries = 0;

	// Core model state and expected register mirror
	zipdbg_pkg::dbg_word_t core_regs [32];
	zipdbg_pkg::dbg_word_t exp_regs [32];
	zipdbg_pkg::dbg_word_t lcg_state = 32'd8;
	int errors = 0;
	int checks = 0;

	// Monitor results, sampled on the falling edge
	int reset_cycles;
	logic cc_seen, we_seen;
	zipdbg_pkg::cpu_reg_t last_wreg;
	zipdbg_pkg::dbg_word_t last_wdata;

	tb_clock u_clock (.o_clk(clk));

	zipdbg_top zipdbg_top_i (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(aresetn),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
		.o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
		.o_dbg_we(dbg_we), .o_dbg_wreg(dbg_wreg), .o_dbg_data(dbg_data),
		.o_dbg_rreg(dbg_rreg), .i_dbg_reg(core_rdata), .i_dbg_stall(dbg_stall),
		.i_cpu_reset(cpu_reset), .i_interrupt(interrupt), .i_dbg_break(dbg_break),
		.i_dbg_cc(dbg_cc), .o_halt(halt), .o_cmd_reset(cmd_reset),
		.o_clear_cache(clear_cache)
	);

	//////////////////////////////////////////////////////////////////////
	// Core model
	//////////////////////////////////////////////////////////////////////
	// Running core reports stall
	assign dbg_stall = !halt;

	always @(posedge clk)
	begin
		if (dbg_we)
			core_regs[dbg_wreg] <= dbg_data;
		// Register file answers one cycle after the read number
		core_rdata <= core_regs[dbg_rreg];
	end

	always @(negedge clk)
	begin
		if (cmd_reset)
			reset_cycles = reset_cycles + 1;
		if (clear_cache)
			cc_seen = 1'b1;
		if (dbg_we)
		begin
			we_seen = 1'b1;
			last_wreg = dbg_wreg;
			last_wdata = dbg_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic check_word(input string name, input zipdbg_pkg::dbg_word_t got,
		input zipdbg_pkg::dbg_word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input zipdbg_pkg::cpu_reg_t got,
		input zipdbg_pkg::cpu_reg_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%01h, expected 0x%01h", name, got, exp);
		end
	endtask

	task automatic check_resp(input string name, input zipdbg_pkg::bus_resp_t got);
		checks++;
		if (got !== 2'b00)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%01h, expected 0x0", name, got);
		end
	endtask

	function automatic zipdbg_pkg::dbg_word_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic add_entry(input int o, input zipdbg_pkg::dbg_addr_t a,
		input zipdbg_pkg::dbg_word_t d, input zipdbg_pkg::dbg_strb_t s,
		input zipdbg_pkg::dbg_word_t e);
		op[n_entries] = o;
		t_addr[n_entries] = a;
		t_data[n_entries] = d;
		t_strb[n_entries] = s;
		t_expect[n_entries] = e;
		n_entries++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus transfers
	//////////////////////////////////////////////////////////////////////
	task automatic bus_write(input zipdbg_pkg::dbg_addr_t a, input zipdbg_pkg::dbg_word_t d,
		input zipdbg_pkg::dbg_strb_t s);
		logic aw_fire;
		logic w_fire;
		@(negedge clk);
		awvalid = 1'b1;
		awaddr = a;
		wvalid = 1'b1;
		wdata = d;
		wstrb = s;
		// Ready is a register, stable at the falling edge
		do
		begin
			aw_fire = awvalid && awready;
			w_fire = wvalid && wready;
			@(negedge clk);
			if (aw_fire)
				awvalid = 1'b0;
			if (w_fire)
				wvalid = 1'b0;
		end while (awvalid || wvalid);
		while (!bvalid)
			@(negedge clk);
		check_resp("o_bresp", bresp);
		@(negedge clk);
	endtask

	task automatic bus_read(input zipdbg_pkg::dbg_addr_t a, input int hold,
		output zipdbg_pkg::dbg_word_t d);
		logic fire;
		zipdbg_pkg::dbg_word_t held;
		@(negedge clk);
		arvalid = 1'b1;
		araddr = a;
		rready = (hold == 0);
		do
		begin
			fire = arready;
			@(negedge clk);
		end while (!fire);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		// Back-pressure, data must hold while the status word moves
		held = rdata;
		if (hold > 0)
			interrupt = 1'b1;
		for (int i = 0; i < hold; i++)
		begin
			@(negedge clk);
			check_bit("o_rvalid", rvalid, 1'b1);
			check_word("o_rdata held", rdata, held);
		end
		rready = 1'b1;
		d = rdata;
		check_resp("o_rresp", rresp);
		@(negedge clk);
		interrupt = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		repeat (16 + zipdbg_pkg::RESET_DURATION + 200 * NUM_ENTRIES) @(posedge clk);
		$display("Timeout: the DUT stopped answering bus transfers");
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		zipdbg_pkg::dbg_word_t got;
		zipdbg_pkg::dbg_word_t val;
		zipdbg_pkg::cpu_reg_t r;
		aresetn = 1'b0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b1;
		rready = 1'b1;
		cpu_reset = 1'b0;
		interrupt = 1'b0;
		dbg_break = 1'b0;
		dbg_cc = '0;
		core_rdata = '0;
		reset_cycles = 0;
		cc_seen = 1'b0;
		we_seen = 1'b0;
		// Fill pattern over the whole register number
		for (int i = 0; i < 32; i++)
		begin
			core_regs[i] = 32'hA5C30000 ^ (i * 32'h01010101);
			exp_regs[i] = core_regs[i];
		end

		// Status: 0 halt request, 1 halted, 5 catch
		add_entry(OP_READ, 8'h00, 0, 0, 32'h23);
		// Running core, so the first register write has to halt it
		add_entry(OP_WRITE, 8'h00, 32'h20, 4'h1, 0);
		add_entry(OP_CPUWR, 8'h8C, 0, 4'hF, 0);
		add_entry(OP_CPUWR, 8'hC4, 0, 4'hF, 0);
		add_entry(OP_CPUWR, 8'hF8, 0, 4'hF, 0);
		add_entry(OP_CPURD, 8'h8C, 0, 0, 0);
		add_entry(OP_CPURD, 8'hC4, 0, 0, 0);
		add_entry(OP_CPURD, 8'hF8, 0, 0, 0);
		add_entry(OP_READ, 8'h00, 0, 0, 32'h23);
		// Release, halt, step; write expect is reset cycles, bit 4 clear-cache
		add_entry(OP_WRITE, 8'h00, 32'h20, 4'h1, 0);
		add_entry(OP_READ, 8'h00, 0, 0, 32'h20);
		add_entry(OP_WRITE, 8'h00, 32'h21, 4'h1, 0);
		add_entry(OP_READ, 8'h00, 0, 0, 32'h23);
		add_entry(OP_WRITE, 8'h00, 32'h24, 4'h1, 0);
		add_entry(OP_READ, 8'h00, 0, 0, 32'h23);
		add_entry(OP_WRITE, 8'h00, 32'h29, 4'h1, 32'h01);
		add_entry(OP_READ, 8'h00, 0, 0, 32'h23);
		add_entry(OP_WRITE, 8'h00, 32'h31, 4'h1, 32'h10);
		add_entry(OP_READ, 8'h00, 0, 0, 32'h23);
		// Catch cleared, break gives reset; break expect bit 5 is halt
		add_entry(OP_WRITE, 8'h00, 32'h01, 4'h1, 0);
		add_entry(OP_READ, 8'h00, 0, 0, 32'h03);
		add_entry(OP_BREAK, 8'h00, 0, 0, 32'h21);
		add_entry(OP_WRITE, 8'h00, 32'h21, 4'h1, 0);
		add_entry(OP_WRITE, 8'h00, 32'h20, 4'h1, 0);
		add_entry(OP_READ, 8'h00, 0, 0, 32'h20);
		add_entry(OP_BREAK, 8'h00, 0, 0, 32'h20);
		add_entry(OP_RDHOLD, 8'h00, 0, 0, 32'h23);

		repeat (16) @(negedge clk);
		aresetn = 1'b1;
		repeat (zipdbg_pkg::RESET_DURATION + 2) @(negedge clk);
		check_bit("o_cmd_reset", cmd_reset, 1'b0);
		check_bit("o_bvalid", bvalid, 1'b0);
		check_bit("o_clear_cache", clear_cache, 1'b0);

		for (int k = 0; k < n_entries; k++)
		begin
			reset_cycles = 0;
			cc_seen = 1'b0;
			we_seen = 1'b0;
			case (op[k])
				OP_WRITE:
				begin
					bus_write(t_addr[k], t_data[k], t_strb[k]);
					repeat (3) @(negedge clk);
					check_word("o_cmd_reset cycles", reset_cycles, {28'h0, t_expect[k][3:0]});
					check_bit("o_clear_cache seen", cc_seen, t_expect[k][4]);
					check_bit("o_clear_cache", clear_cache, 1'b0);
				end
				OP_READ, OP_RDHOLD:
				begin
					bus_read(t_addr[k], (op[k] == OP_RDHOLD) ? 5 : 0, got);
					check_word("o_rdata", got, t_expect[k]);
				end
				OP_BREAK:
				begin
					@(negedge clk);
					dbg_break = 1'b1;
					@(negedge clk);
					dbg_break = 1'b0;
					repeat (3) @(negedge clk);
					check_word("o_cmd_reset cycles", reset_cycles, {28'h0, t_expect[k][3:0]});
					check_bit("o_halt", halt, t_expect[k][5]);
				end
				OP_CPUWR:
				begin
					val = lcg_next();
					r = t_addr[k][6:2];
					bus_write(t_addr[k], val, t_strb[k]);
					repeat (3) @(negedge clk);
					exp_regs[r] = val;
					check_bit("o_dbg_we seen", we_seen, 1'b1);
					check_reg("o_dbg_wreg", last_wreg, r);
					check_word("o_dbg_data", last_wdata, val);
					check_bit("o_halt", halt, 1'b1);
				end
				OP_CPURD:
				begin
					r = t_addr[k][6:2];
					bus_read(t_addr[k], 0, got);
					check_word("o_rdata cpu", got, exp_regs[r]);
				end
				default:
				begin
					errors++;
					$display("Unknown operation in the stimulus table at entry %0d", k);
				end
			endcase
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: zipdbg.f
verilog/zipdbg_pkg.sv
verilog/dbg_skidbuffer.sv
verilog/dbg_axil_slave.sv
verilog/dbg_control.sv
verilog/zipdbg_top.sv
tests/tb_clock.sv
tests/zipdbg_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug wrapper testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f zipdbg.f --top-module zipdbg_tb \
	-Mdir obj_dir -o zipdbg_sim

./obj_dir/zipdbg_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1
